//--- run.sh
#!/bin/sh
# Build and run the transpose testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f src.f --top-module tb_inner_shuffle \
	-Mdir obj_dir -o sim_inner_shuffle
./obj_dir/sim_inner_shuffle 2>&1 | tee sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "Run ended without a result line"
	exit 1
fi

//--- src.f
+incdir+src
src/shuffle_pkg.sv
src/bank_array.sv
src/write_rotator.sv
src/read_index_counter.sv
src/read_lane_router.sv
src/page_controller.sv
src/inner_shuffle.sv
verif/tb_inner_shuffle.sv

//--- src/bank_array.sv
/*
  SIMD element-wide banks sharing one write address
  Every bank has its own read address and a registered read port
  Read data holds while rd_en is low, memory content has no reset
*/
`timescale 1ns/1ps
`default_nettype none
`include "shuffle_config.svh"

module bank_array (
	input  logic                   clk,
	input  logic                   wr_en,
	input  shuffle_pkg::bank_addr_t wr_addr,
	input  shuffle_pkg::beat_t     wr_data,
	input  logic                   rd_en,
	input  shuffle_pkg::bank_addr_t rd_addr [`SHUF_SIMD],
	output shuffle_pkg::beat_t     rd_data
);
	import shuffle_pkg::*;

	for (genvar b = 0; b < `SHUF_SIMD; b++) begin : gen_bank
		elem_t mem [bank_depth];   // Both pages of this bank

		// Common write address, one lane of wr_data per bank
		always_ff @(posedge clk) begin
			if (wr_en)
				mem[wr_addr] <= wr_data[b];
		end

		// Registered read, frozen while the pipeline stalls
		always_ff @(posedge clk) begin
			if (rd_en)
				rd_data[b] <= mem[rd_addr[b]];
		end
	end

endmodule

`default_nettype wire

//--- src/inner_shuffle.sv
/*
  Streaming transpose of an I x J row-major matrix, SIMD elements per beat
  Output is column by column, SIMD rows per beat, one beat per cycle
  Two jobs are buffered, first output 3 cycles after the last input of a job
*/
`timescale 1ns/1ps
`default_nettype none
`include "shuffle_config.svh"

module inner_shuffle (
	input  logic               clk,
	input  logic               rst,
	input  logic               ivld,
	output logic               irdy,
	input  shuffle_pkg::beat_t idat,
	output logic               ovld,
	input  logic               ordy,
	output shuffle_pkg::beat_t odat
);
	import shuffle_pkg::*;

	// Write path
	logic       wr_en;
	bank_addr_t wr_addr;
	beat_t      wr_data;
	logic       wr_page_done;
	logic       wr_page;

	// Read path
	logic                       rd_issue;
	logic                       advance;
	logic                       rd_page;
	logic [$clog2(`SHUF_I)-1:0] i_base;
	logic [$clog2(`SHUF_J)-1:0] j_idx;
	logic                       last_beat;
	bank_addr_t                 bank_rd_addr [`SHUF_SIMD];
	beat_t                      bank_rd_data;
	beat_t                      rd_beat;

	write_rotator u_wr (.clk, .rst, .ivld, .irdy, .idat, .wr_en, .wr_addr, .wr_data,
		.wr_page_done, .wr_page);

	bank_array u_banks (.clk, .wr_en, .wr_addr, .wr_data, .rd_en(advance),
		.rd_addr(bank_rd_addr), .rd_data(bank_rd_data));

	read_index_counter u_idx (.clk, .rst, .rd_issue, .i_base, .j_idx, .last_beat);

	read_lane_router u_route (.clk, .rst, .advance, .rd_page, .i_base, .j_idx,
		.rd_addr(bank_rd_addr), .rd_data(bank_rd_data), .rd_beat);

	page_controller u_ctrl (.clk, .rst, .wr_page_done, .wr_page, .last_beat, .ordy,
		.rd_beat, .irdy, .rd_issue, .advance, .rd_page, .ovld, .odat);

endmodule

`default_nettype wire

//--- src/page_controller.sv
/*
  Job scheduling and output stage
  Two page flags, pages are read in the order they were written
  irdy drops only while both pages wait to be read
  Pipeline is issue, bank read, output register, all moved by advance
*/
`timescale 1ns/1ps
`default_nettype none

module page_controller (
	input  logic               clk,
	input  logic               rst,
	input  logic               wr_page_done,
	input  logic               wr_page,
	input  logic               last_beat,
	input  logic               ordy,
	input  shuffle_pkg::beat_t rd_beat,
	output logic               irdy,
	output logic               rd_issue,
	output logic               advance,
	output logic               rd_page,
	output logic               ovld,
	output shuffle_pkg::beat_t odat
);
	import shuffle_pkg::*;

	logic [1:0] page_full;      // One flag per page
	rd_state_e  state;
	logic       bank_vld;       // Beat in the bank stage
	logic       out_vld;        // Beat in the output register
	logic       page_release;   // Last issue of the job

	assign irdy         = ~(page_full[0] & page_full[1]);
	assign advance      = ~out_vld | ordy;   // Output register free or leaving
	assign rd_issue     = (state == RD_ACTIVE) && page_full[rd_page] && advance;
	assign page_release = rd_issue && last_beat;
	assign ovld         = out_vld;

	// ----------------------------------------
	// Page flags and read page
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			page_full <= 2'b00;
			rd_page   <= 1'b0;
		end else begin
			if (page_release) begin
				page_full[rd_page] <= 1'b0;
				rd_page            <= ~rd_page;
			end
			if (wr_page_done)
				page_full[wr_page] <= 1'b1;   // Never the page being released
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= RD_IDLE;
		else begin
			case (state)
				RD_IDLE:   if (page_full[rd_page]) state <= RD_ACTIVE;
				RD_ACTIVE: if (page_release) state <= RD_IDLE;
				default:   state <= RD_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// Valid pipeline and output register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			bank_vld <= 1'b0;
			out_vld  <= 1'b0;
		end else if (advance) begin
			bank_vld <= rd_issue;
			out_vld  <= bank_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (advance)
			odat <= rd_beat;   // Holds while stalled
	end

endmodule

`default_nettype wire

//--- src/read_index_counter.sv
/*
  Output order counters, column by column with SIMD rows per beat
  Counters step only on rd_issue and wrap to zero after the last beat
*/
`timescale 1ns/1ps
`default_nettype none
`include "shuffle_config.svh"

module read_index_counter (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          rd_issue,
	output logic [$clog2(`SHUF_I)-1:0]    i_base,
	output logic [$clog2(`SHUF_J)-1:0]    j_idx,
	output logic                          last_beat
);
	localparam int iw = $clog2(`SHUF_I);
	localparam int jw = $clog2(`SHUF_J);

	logic col_end;   // Bottom block of the current column
	logic row_end;   // Last column

	assign col_end   = (i_base == iw'(`SHUF_I - `SHUF_SIMD));
	assign row_end   = (j_idx == jw'(`SHUF_J - 1));
	assign last_beat = col_end && row_end;   // Final beat of the page

	always_ff @(posedge clk) begin
		if (rst) begin
			i_base <= '0;
			j_idx  <= '0;
		end else if (rd_issue) begin
			if (col_end) begin
				i_base <= '0;   // Back to the top row
				j_idx  <= row_end ? '0 : j_idx + 1'b1;
			end else begin
				i_base <= i_base + iw'(`SHUF_SIMD);   // Next block of rows
			end
		end
	end

endmodule

`default_nettype wire

//--- src/read_lane_router.sv
/*
  Read address generation and output remap
  Each lane finds its bank from the write rotation of its element
  Lanes of one beat always land in distinct banks
  Remap uses the bank selection of the previous issue, held on stall
*/
`timescale 1ns/1ps
`default_nettype none
`include "shuffle_config.svh"

module read_lane_router (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          advance,
	input  logic                          rd_page,
	input  logic [$clog2(`SHUF_I)-1:0]    i_base,
	input  logic [$clog2(`SHUF_J)-1:0]    j_idx,
	output shuffle_pkg::bank_addr_t       rd_addr [`SHUF_SIMD],
	input  shuffle_pkg::beat_t            rd_data,
	output shuffle_pkg::beat_t            rd_beat
);
	import shuffle_pkg::*;

	lane_idx_t  lane_bank [`SHUF_SIMD];   // Bank holding each lane's element
	bank_addr_t lane_addr [`SHUF_SIMD];   // Address inside that bank
	lane_idx_t  sel_q     [`SHUF_SIMD];   // Selection of the beat in the bank stage
	bank_addr_t page_base;

	assign page_base = rd_page ? bank_addr_t'(page_depth) : '0;

	// ----------------------------------------
	// Per lane bank and address
	// ----------------------------------------
	always_comb begin : lane_calc
		int e;     // Element index in the job
		int w;     // Write beat that carried it
		int src;   // Input lane it came in on
		int rot;   // Bank offset at that write
		for (int k = 0; k < `SHUF_SIMD; k++) begin
			e   = (int'(i_base) + k) * `SHUF_J + int'(j_idx);
			w   = e / `SHUF_SIMD;
			src = e % `SHUF_SIMD;
			rot = (w / wr_rot_period) % wr_rotations;
			lane_bank[k] = lane_idx_t'((src + rot) % `SHUF_SIMD);
			lane_addr[k] = page_base + bank_addr_t'(w);
		end
	end

	// Each bank takes the address of the lane mapped to it
	always_comb begin : bank_route
		for (int b = 0; b < `SHUF_SIMD; b++)
			rd_addr[b] = '0;
		for (int k = 0; k < `SHUF_SIMD; k++)
			rd_addr[lane_bank[k]] = lane_addr[k];
	end

	// ----------------------------------------
	// Remap one cycle later
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < `SHUF_SIMD; k++)
				sel_q[k] <= '0;
		end else if (advance) begin
			sel_q <= lane_bank;   // Moves with the bank read
		end
	end

	always_comb begin
		for (int k = 0; k < `SHUF_SIMD; k++)
			rd_beat[k] = rd_data[sel_q[k]];   // Back to row order
	end

endmodule

`default_nettype wire

//--- src/shuffle_config.svh
/*
  Fixed configuration of the streaming transpose unit
  SHUF_I must be a multiple of SHUF_SIMD, nothing checks it in hardware
  A job is one SHUF_I x SHUF_J matrix fed row-major, SHUF_SIMD elements per beat
  Changing a value here changes every module, none of them take parameters
*/
`ifndef SHUFFLE_CONFIG_SVH
`define SHUFFLE_CONFIG_SVH

// ----------------------------------------
// Element and matrix shape
// ----------------------------------------
`define SHUF_BITS 8   // Bits per element
`define SHUF_I    8   // Rows of the input matrix
`define SHUF_J    6   // Columns of the input matrix

// ----------------------------------------
// Parallelism
// ----------------------------------------
`define SHUF_SIMD 4   // Elements per beat, also the bank count

`endif

//--- src/shuffle_pkg.sv
/*
  Derived constants and shared types of the transpose unit
  Bank memory holds two pages, each of I*J/SIMD words per bank
*/
`default_nettype none
`include "shuffle_config.svh"

package shuffle_pkg;

	// Greatest common divisor, evaluated at elaboration only
	function automatic int gcd(input int a, input int b);
		int t;
		while (b != 0) begin
			t = b;
			b = a % b;
			a = t;
		end
		return a;
	endfunction

	localparam int page_depth    = `SHUF_I * `SHUF_J / `SHUF_SIMD; // Words per bank per job
	localparam int bank_depth    = 2 * page_depth;                  // Two pages
	localparam int wr_rotations  = gcd(`SHUF_J, `SHUF_SIMD);        // Distinct bank offsets
	localparam int wr_rot_period = `SHUF_J / wr_rotations;          // Writes per offset

	typedef logic [`SHUF_BITS-1:0]            elem_t;
	typedef elem_t [`SHUF_SIMD-1:0]           beat_t;      // Lane 0 in the low bits
	typedef logic [$clog2(bank_depth)-1:0]    bank_addr_t;
	typedef logic [$clog2(`SHUF_SIMD)-1:0]    lane_idx_t;

	typedef enum logic {RD_IDLE, RD_ACTIVE} rd_state_e;

endpackage

`default_nettype wire

//--- src/write_rotator.sv
/*
  Write side of the transpose unit
  Input beats go to consecutive bank addresses across both pages
  The lane-to-bank offset steps every wr_rot_period writes, mod wr_rotations
  The offset sequence restarts on every page boundary by construction
*/
`timescale 1ns/1ps
`default_nettype none
`include "shuffle_config.svh"

module write_rotator (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ivld,
	input  logic                    irdy,
	input  shuffle_pkg::beat_t      idat,
	output logic                    wr_en,
	output shuffle_pkg::bank_addr_t wr_addr,
	output shuffle_pkg::beat_t      wr_data,
	output logic                    wr_page_done,
	output logic                    wr_page
);
	import shuffle_pkg::*;

	bank_addr_t addr_q;   // 0 .. bank_depth-1

	assign wr_en   = ivld && irdy;   // Input handshake
	assign wr_addr = addr_q;
	assign wr_page = (addr_q >= bank_addr_t'(page_depth));   // Upper half is page 1
	assign wr_page_done = wr_en && ((addr_q == bank_addr_t'(page_depth - 1)) ||
		(addr_q == bank_addr_t'(bank_depth - 1)));

	always_ff @(posedge clk) begin
		if (rst)
			addr_q <= '0;
		else if (wr_en)
			addr_q <= (addr_q == bank_addr_t'(bank_depth - 1)) ? '0 : addr_q + 1'b1;
	end

	// ----------------------------------------
	// Bank rotation
	// ----------------------------------------
	if (wr_rotations == 1) begin : gen_no_rot
		assign wr_data = idat;   // Columns already spread over all banks
	end else begin : gen_rot
		localparam int rot_w = $clog2(wr_rotations);
		logic             rotate;   // Last write of the current offset
		logic [rot_w-1:0] rot_q;    // Current bank offset

		if (wr_rot_period == 1) begin : gen_rot_each
			assign rotate = 1'b1;
		end else begin : gen_rep_cnt
			localparam int rep_w = $clog2(wr_rot_period);
			logic [rep_w-1:0] rep_q;
			assign rotate = (rep_q == rep_w'(wr_rot_period - 1));
			always_ff @(posedge clk) begin
				if (rst)
					rep_q <= '0;
				else if (wr_en)
					rep_q <= rotate ? '0 : rep_q + 1'b1;
			end
		end

		always_ff @(posedge clk) begin
			if (rst)
				rot_q <= '0;
			else if (wr_en && rotate)
				rot_q <= (rot_q == rot_w'(wr_rotations - 1)) ? '0 : rot_q + 1'b1;
		end

		// Bank b takes lane (b - offset) mod SIMD
		always_comb begin
			for (int b = 0; b < `SHUF_SIMD; b++)
				wr_data[b] = idat[(b + `SHUF_SIMD - int'(rot_q)) % `SHUF_SIMD];
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_inner_shuffle.sv
/*
  Self-checking testbench of the streaming transpose unit
  Every input job is kept in a queue, outputs are checked against a transpose model
  Inputs change 1 ns after the rising edge, outputs are sampled at the edge
  Stops at the first mismatch, run length is bounded by a cycle counter
*/
`timescale 1ns/1ps
`default_nettype none
`include "shuffle_config.svh"

module tb_inner_shuffle;
	import shuffle_pkg::*;

	localparam int elems          = `SHUF_I * `SHUF_J;
	localparam int blocks         = `SHUF_I / `SHUF_SIMD;        // Beats per column
	localparam int timeout_cycles = 8 * page_depth * 4 + 200;

	typedef logic [elems*`SHUF_BITS-1:0] mat_t;   // Element e at bits e*BITS

	logic  clk = 1'b0;
	logic  rst;
	logic  ivld;
	logic  irdy;
	beat_t idat;
	logic  ovld;
	logic  ordy;
	beat_t odat;

	integer seed = 32'h171d;
	mat_t   job_q [$];    // Jobs sent but not yet fully checked
	int     jobs_sent;
	int     out_count;    // Output beats seen over the whole run
	int     beat_n;       // Beat number inside the current output job
	int     cycles;
	int     errors;
	bit     in_gaps;      // Random idle cycles on the input side
	int     ordy_mode;    // 0 high, 1 random, 2 low
	bit     hold_pending; // Last edge saw ovld without ordy
	beat_t  held;

	inner_shuffle UUT (.clk, .rst, .ivld, .irdy, .idat, .ovld, .ordy, .odat);

	always #2 clk = ~clk;   // 4 ns period

	// ----------------------------------------
	// Reference model and checks
	// ----------------------------------------
	function automatic beat_t ref_beat(input mat_t mat, input int n);
		beat_t b;
		int    i;
		int    j;
		j = n / blocks;               // Column of this beat
		i = (n % blocks) * `SHUF_SIMD; // First row of this beat
		for (int k = 0; k < `SHUF_SIMD; k++)
			b[k] = mat[((i + k) * `SHUF_J + j) * `SHUF_BITS +: `SHUF_BITS];
		return b;
	endfunction

	task automatic fail_run(input string why);
		errors++;
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected)
			fail_run($sformatf("Error at %0d ns: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	// ----------------------------------------
	// Stimulus helpers
	// ----------------------------------------
	task automatic send_beat(input beat_t b);
		if (in_gaps) begin
			while (($random(seed) & 3) == 0) begin   // About one gap in four
				ivld = 1'b0;
				@(posedge clk);
				#1;
			end
		end
		ivld = 1'b1;
		idat = b;
		@(posedge clk);
		while (!irdy)
			@(posedge clk);   // Back-pressure
		#1 ivld = 1'b0;
	endtask

	task automatic send_job(input bit counting);
		mat_t  mat;
		beat_t b;
		for (int e = 0; e < elems; e++)
			mat[e*`SHUF_BITS +: `SHUF_BITS] = counting ? elem_t'(e) : elem_t'($random(seed));
		job_q.push_back(mat);
		jobs_sent++;
		for (int w = 0; w < page_depth; w++) begin
			for (int l = 0; l < `SHUF_SIMD; l++)
				b[l] = mat[(w * `SHUF_SIMD + l) * `SHUF_BITS +: `SHUF_BITS];   // Row-major
			send_beat(b);
		end
	endtask

	// Wait until every job sent so far has come out, then nothing more may follow
	task automatic drain();
		while (out_count < jobs_sent * page_depth) begin
			@(posedge clk);
			#1;
		end
		check_value(64'(ovld), 64'd0, "ovld after all jobs drained");
	endtask

	// ordy driver, mode taken at the edge and applied 1 ns later
	initial begin : ordy_drive
		int mode_now;
		ordy = 1'b1;
		forever begin
			@(posedge clk);
			mode_now = ordy_mode;
			#1;
			case (mode_now)
				1:       ordy = (($random(seed) & 3) != 0);
				2:       ordy = 1'b0;
				default: ordy = 1'b1;
			endcase
		end
	end

	// ----------------------------------------
	// Output compare and run limit
	// ----------------------------------------
	always @(posedge clk) begin
		if (!rst) begin
			if (hold_pending) begin   // Stalled beat must stay put
				check_value(64'(ovld), 64'd1, "ovld dropped while stalled");
				check_value(64'(odat), 64'(held), "odat changed while stalled");
			end
			if (ovld && ordy) begin
				if (job_q.size() == 0) begin
					fail_run("An output beat arrived with no job left to check");
				end else begin
					check_value(64'(odat), 64'(ref_beat(job_q[0], beat_n)), "output beat");
					out_count++;
					beat_n++;
					if (beat_n == page_depth) begin   // Job complete
						beat_n = 0;
						void'(job_q.pop_front());
					end
				end
			end
			hold_pending = ovld && !ordy;
			held         = odat;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_cycles)
			fail_run("Timeout: the DUT did not finish all jobs in time");
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		rst          = 1'b1;
		ivld         = 1'b0;
		idat         = '0;
		in_gaps      = 1'b0;
		ordy_mode    = 0;
		jobs_sent    = 0;
		out_count    = 0;
		beat_n       = 0;
		cycles       = 0;
		errors       = 0;
		hold_pending = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;

		check_value(64'(irdy), 64'd1, "irdy after reset");
		check_value(64'(ovld), 64'd0, "ovld after reset");

		send_job(1'b1);   // Counting values
		drain();

		repeat (8) send_job(1'b0);   // Back to back, no stalls
		drain();

		in_gaps   = 1'b1;
		ordy_mode = 1;
		repeat (4) send_job(1'b0);
		drain();
		in_gaps   = 1'b0;

		// Both pages filled behind a stalled output
		ordy_mode = 2;
		send_job(1'b0);
		send_job(1'b0);
		check_value(64'(irdy), 64'd0, "irdy with both pages full");
		repeat (4) begin
			@(posedge clk);
			#1;
			check_value(64'(irdy), 64'd0, "irdy while output is stalled");
		end
		ordy_mode = 0;
		drain();
		check_value(64'(irdy), 64'd1, "irdy after both jobs drained");

		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
